//--- all.f
+incdir+common
common/consoleTypes_pkg.sv
hdl/consoleRegs.sv
hdl/fontStore.sv
hdl/charDispatcher.sv
render/fontShapeRenderer.sv
render/sramWritePort.sv
hdl/consoleTop.sv
bench/consoleTop_asserts.sv
bench/consoleTop_tb.sv

//--- bench/consoleTop_asserts.sv
`timescale 1ns/10ps

module consoleTop_asserts #(
    parameter bit StrobeRegistered = 1'b0
) (
    input logic clk,
    input logic rst,
    input logic den,
    input logic weN,
    input logic idle,
    input logic complete
);

    int failCount = 0;

    // On the external bus the write strobe lags the request by one register stage.
    property writeNeedsEnable;
        @(posedge clk) disable iff (rst)
            !weN |-> (StrobeRegistered ? $past(den) : den);
    endproperty

    assert property (writeNeedsEnable)
        else begin
            $error("Write strobe low without a request enable.");
            failCount++;
        end

    // A completion must arrive while the requester still holds its write.
    assert property (@(posedge clk) disable iff (rst) !(idle && complete))
        else begin
            $error("Write completion reported while the requester is idle.");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (rst) complete |=> !complete)
        else begin
            $error("Write completion pulsed on two consecutive cycles.");
            failCount++;
        end

endmodule

bind fontShapeRenderer consoleTop_asserts #(.StrobeRegistered(1'b0)) rendererChecks_i (
    .clk, .rst, .den(ramRequest.den), .weN(ramRequest.we_n), .idle(done),
    .complete(ramResult.done)
);

bind sramWritePort consoleTop_asserts #(.StrobeRegistered(1'b1)) busChecks_i (
    .clk, .rst, .den(ramRequest.den), .weN(sramBus.weN), .idle(!ramRequest.den),
    .complete(ramResult.done)
);

//--- bench/consoleTop_tb.sv
`timescale 1ns/10ps
`include "console_defines.svh"

module consoleTop_tb;

    localparam int ClockPeriod = 40;
    localparam int StepCount = 6;
    localparam int GlyphsUsed = 3;
    localparam int LineStride = `CONSOLE_COLUMNS * `WIDTH_PER_CHARACTER;
    localparam int RowStride = `HEIGHT_PER_CHARACTER * LineStride;
    // Glyph read, fontReady, INIT, the pixel writes and the final busy update.
    localparam int DrawLatency = 3 + `PIXEL_PER_CHARACTER * `SRAM_WRITE_CYCLES + 1;
    localparam int UploadCycles = GlyphsUsed * `HEIGHT_PER_CHARACTER * 2;
    localparam int WatchdogCycles = StepCount * 300 + UploadCycles + 20;

    typedef struct packed {
        logic [15:0]                    foreground;
        logic [15:0]                    background;
        logic [19:0]                    frameBase;
        consoleTypes_pkg::DrawCommand_t command;
        logic                           recolourDuringDraw;
        logic                           drawWhileBusy;
        logic                           reloadRow;
        logic [3:0]                     rowToReload;
    } TestStep_t;

    logic clk, rst, regWrite, glyphWrite, drawChar, busy;
    consoleTypes_pkg::RegSelect_t regSelect;
    logic [19:0] regData;
    logic [6:0] glyphCode;
    logic [3:0] glyphRow;
    logic [7:0] glyphBits;
    consoleTypes_pkg::DrawCommand_t drawCommand;
    consoleTypes_pkg::SramBus_t sramBus;

    TestStep_t steps [StepCount];
    string stepNames [StepCount];
    logic [7:0] glyphRows [`GLYPH_COUNT][`HEIGHT_PER_CHARACTER];
    logic [15:0] sramModel [int]; // Pixel data by address.
    int writeCount;
    int activeCycles;
    int errorCount;
    int passedSteps;
    int seed;

    consoleTop dut_i (
        .clk, .rst, .regWrite, .regSelect, .regData, .glyphWrite, .glyphCode, .glyphRow,
        .glyphBits, .drawChar, .drawCommand, .busy, .sramBus
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    // A pixel is complete in the cycle where the write port pulses done.
    always @(negedge clk) begin
        if (!rst && !sramBus.ceN) activeCycles++;
        if (!rst && !sramBus.ceN && !sramBus.weN && dut_i.ramResult.done) begin
            sramModel[int'(sramBus.address)] = sramBus.data;
            writeCount++;
        end
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles without finishing the steps.", WatchdogCycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic fillTable();
        steps[0] = '{16'hFFFF, 16'h0000, 20'h00000, '{7'd1, 5'd0, 7'd0}, 1'b0, 1'b0, 1'b0, 4'd0};
        steps[1] = '{16'hF800, 16'h001F, 20'h01000, '{7'd2, 5'd3, 7'd5}, 1'b0, 1'b0, 1'b0, 4'd0};
        steps[2] = '{16'h07E0, 16'h1234, 20'h01000, '{7'd2, 5'd3, 7'd6}, 1'b0, 1'b0, 1'b0, 4'd0};
        steps[3] = '{16'hAAAA, 16'h5555, 20'h00400, '{7'd3, 5'd10, 7'd20}, 1'b1, 1'b0, 1'b0, 4'd0};
        steps[4] = '{16'h0F0F, 16'hF0F0, 20'h00000, '{7'd1, 5'd29, 7'd79}, 1'b0, 1'b1, 1'b0, 4'd0};
        steps[5] = '{16'hF800, 16'h001F, 20'h01000, '{7'd2, 5'd3, 7'd5}, 1'b0, 1'b0, 1'b1, 4'd7};
        stepNames = '{"origin_cell", "offset_cell", "recoloured_cell", "register_write_mid_draw",
                      "draw_strobe_while_busy", "reloaded_glyph_row"};
    endtask

    task automatic nextDriveSlot();
        @(posedge clk);
        #5;
    endtask

    task automatic writeRegister(input consoleTypes_pkg::RegSelect_t select,
                                 input logic [19:0] value);
        nextDriveSlot();
        regWrite = 1'b1;
        regSelect = select;
        regData = value;
        nextDriveSlot();
        regWrite = 1'b0;
    endtask

    task automatic uploadRow(input int code, input int row, input logic [7:0] bits);
        nextDriveSlot();
        glyphWrite = 1'b1;
        glyphCode = 7'(code);
        glyphRow = 4'(row);
        glyphBits = bits;
        glyphRows[code][row] = bits;
        nextDriveSlot();
        glyphWrite = 1'b0;
    endtask

    // Counts the rising edges from acceptance until busy is seen low.
    task automatic drawCell(input int s, output int latency);
        nextDriveSlot();
        drawChar = 1'b1;
        drawCommand = steps[s].command;
        @(posedge clk);
        #5;
        drawChar = 1'b0;
        latency = 0;
        forever begin
            @(negedge clk);
            if (!busy) break;
            @(posedge clk);
            latency++;
            #5;
            regWrite = 1'b0;
            drawChar = 1'b0;
            if (latency == 20 && steps[s].recolourDuringDraw) begin
                regWrite = 1'b1;
                regSelect = consoleTypes_pkg::REG_FOREGROUND;
                regData = 20'h0BEEF;
            end
            if (latency == 20 && steps[s].drawWhileBusy) begin
                drawChar = 1'b1;
                drawCommand = '{code: 7'd3, row: 5'd0, column: 7'd1};
            end
        end
    endtask

    task automatic checkCell(input int s, input int latency);
        TestStep_t step;
        logic [19:0] cellBase;
        logic [19:0] address;
        logic [15:0] expected;
        step = steps[s];
        cellBase = 20'(step.frameBase + step.command.row * RowStride + step.command.column * 8);
        assert (latency == DrawLatency) else begin
            $display("[ERROR] %s: busy cycles expected %0d, actual %0d",
                     stepNames[s], DrawLatency, latency);
            errorCount++;
        end
        assert (writeCount == `PIXEL_PER_CHARACTER) else begin
            $display("[ERROR] %s: write count expected %0d, actual %0d",
                     stepNames[s], `PIXEL_PER_CHARACTER, writeCount);
            errorCount++;
        end
        assert (sramModel.num() == `PIXEL_PER_CHARACTER) else begin
            $display("[ERROR] %s: distinct addresses expected %0d, actual %0d",
                     stepNames[s], `PIXEL_PER_CHARACTER, sramModel.num());
            errorCount++;
        end
        for (int y = 0; y < `HEIGHT_PER_CHARACTER; y++) begin
            for (int x = 0; x < `WIDTH_PER_CHARACTER; x++) begin
                address = 20'(cellBase + y * LineStride + x);
                expected = glyphRows[step.command.code][y][7 - x] ? step.foreground
                                                                   : step.background;
                assert (sramModel.exists(int'(address))) else begin
                    $display("%s: pixel (%0d,%0d) at address %05h was never written",
                             stepNames[s], x, y, address);
                    errorCount++;
                end
                if (sramModel.exists(int'(address))) begin
                    assert (sramModel[int'(address)] == expected) else begin
                        $display("[ERROR] %s: pixel (%0d,%0d) expected %04h, actual %04h",
                                 stepNames[s], x, y, expected, sramModel[int'(address)]);
                        errorCount++;
                    end
                end
            end
        end
    endtask

    initial begin
        int latency;
        int firstError;
        int assertFailures;
        logic [7:0] bits;
        logic sawBusy;
        rst = 1'b1;
        regWrite = 1'b0;
        regSelect = consoleTypes_pkg::REG_FOREGROUND;
        regData = '0;
        glyphWrite = 1'b0;
        glyphCode = '0;
        glyphRow = '0;
        glyphBits = '0;
        drawChar = 1'b0;
        drawCommand = '0;
        seed = 33823;
        errorCount = 0;
        passedSteps = 0;
        writeCount = 0;
        activeCycles = 0;
        fillTable();
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        assert (busy == 1'b0) else begin
            $display("[ERROR] reset: busy expected 0, actual %b", busy);
            errorCount++;
        end
        assert ({sramBus.ceN, sramBus.weN, sramBus.oeN} == 3'b111) else begin
            $display("[ERROR] reset: bus strobes expected 111, actual %b%b%b",
                     sramBus.ceN, sramBus.weN, sramBus.oeN);
            errorCount++;
        end
        for (int code = 1; code <= GlyphsUsed; code++) begin
            for (int row = 0; row < `HEIGHT_PER_CHARACTER; row++) begin
                bits = 8'($random(seed));
                uploadRow(code, row, bits);
            end
        end
        assert (activeCycles == 0 && writeCount == 0) else begin
            $display("The SRAM bus became active before the first draw command.");
            errorCount++;
        end
        for (int s = 0; s < StepCount; s++) begin
            firstError = errorCount;
            writeRegister(consoleTypes_pkg::REG_FOREGROUND, {4'h0, steps[s].foreground});
            writeRegister(consoleTypes_pkg::REG_BACKGROUND, {4'h0, steps[s].background});
            writeRegister(consoleTypes_pkg::REG_FRAME_BASE, steps[s].frameBase);
            if (steps[s].reloadRow) begin
                // Forcing a low bit change guarantees the row really differs.
                bits = glyphRows[steps[s].command.code][steps[s].rowToReload]
                       ^ (8'($random(seed)) | 8'h01);
                uploadRow(steps[s].command.code, steps[s].rowToReload, bits);
            end
            sramModel.delete();
            writeCount = 0;
            drawCell(s, latency);
            if (steps[s].drawWhileBusy) begin
                // The ignored strobe must not start a second cell once busy falls.
                sawBusy = 1'b0;
                repeat (8) begin
                    @(negedge clk);
                    if (busy) sawBusy = 1'b1;
                end
                assert (!sawBusy) else begin
                    $display("%s: a draw strobe given while busy started another draw",
                             stepNames[s]);
                    errorCount++;
                end
            end
            checkCell(s, latency);
            if (errorCount == firstError) begin
                passedSteps++;
                $display("%s: passed", stepNames[s]);
            end else begin
                $display("%s: failed with %0d errors", stepNames[s], errorCount - firstError);
            end
        end
        assertFailures = dut_i.renderer_i.rendererChecks_i.failCount
                         + dut_i.writePort_i.busChecks_i.failCount;
        if (assertFailures != 0) begin
            $display("%0d concurrent assertion failures on the renderer and the SRAM bus",
                     assertFailures);
        end
        errorCount += assertFailures;
        $display("%0d tests, %0d passed, %0d failed, %0d errors in total",
                 StepCount, passedSteps, StepCount - passedSteps, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- common/consoleTypes_pkg.sv
`include "console_defines.svh"

package consoleTypes_pkg;

    typedef logic [19:0] SramAddress_t; // One address per pixel.
    typedef logic [15:0] Color_t;
    typedef logic [`PIXEL_PER_CHARACTER-1:0] GlyphShape_t; // Bit 127 is pixel (0,0).
    typedef logic [6:0] GlyphCode_t;
    typedef logic [7:0] GlyphRow_t; // Bit 7 is the leftmost pixel.

    typedef struct packed {
        GlyphShape_t shape;
        Color_t      foreground;
        Color_t      background;
    } CharGrid_t;

    typedef struct packed {
        SramAddress_t address;
        Color_t       dout;
        logic         den;
        logic         we_n;
        logic         oe_n;
    } SramRequest_t;

    typedef struct packed {
        logic done;
    } SramResult_t;

    // External SRAM pins, all strobes active low.
    typedef struct packed {
        SramAddress_t address;
        Color_t       data;
        logic         ceN;
        logic         weN;
        logic         oeN;
    } SramBus_t;

    typedef struct packed {
        GlyphCode_t code;
        logic [4:0] row;
        logic [6:0] column;
    } DrawCommand_t;

    typedef enum logic [1:0] {
        REG_FOREGROUND,
        REG_BACKGROUND,
        REG_FRAME_BASE
    } RegSelect_t;

endpackage

//--- common/console_defines.svh
`ifndef CONSOLE_DEFINES_SVH
`define CONSOLE_DEFINES_SVH

// Glyph cell geometry in pixels.
`define WIDTH_PER_CHARACTER 8
`define HEIGHT_PER_CHARACTER 16
`define PIXEL_PER_CHARACTER 128

// Console of 80 by 30 cells, a 640x480 frame buffer.
`define CONSOLE_COLUMNS 80
`define CONSOLE_ROWS 30

`define SRAM_WRITE_CYCLES 2 // Bus cycles per pixel write.

`define GLYPH_COUNT 128

`endif

//--- hdl/charDispatcher.sv
`timescale 1ns/10ps
`include "console_defines.svh"

module charDispatcher (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           drawChar,
    input  consoleTypes_pkg::DrawCommand_t drawCommand,
    input  consoleTypes_pkg::Color_t       foreground,
    input  consoleTypes_pkg::Color_t       background,
    input  consoleTypes_pkg::SramAddress_t frameBase,
    input  consoleTypes_pkg::GlyphShape_t  shape,
    input  logic                           done,
    output consoleTypes_pkg::GlyphCode_t   readCode,
    output consoleTypes_pkg::CharGrid_t    grid,
    output consoleTypes_pkg::SramAddress_t baseAddress,
    output logic                           fontReady,
    output logic                           busy
);

    localparam int LineStride = `CONSOLE_COLUMNS * `WIDTH_PER_CHARACTER;
    localparam int RowStride = `HEIGHT_PER_CHARACTER * LineStride;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        START,
        WAIT_DONE
    } DispatchState_t;

    DispatchState_t state;
    consoleTypes_pkg::DrawCommand_t command;
    consoleTypes_pkg::Color_t fgLatched;
    consoleTypes_pkg::Color_t bgLatched;
    consoleTypes_pkg::SramAddress_t baseLatched;
    logic accept;

    assign accept = (state == IDLE) && drawChar;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            busy      <= 1'b0;
            fontReady <= 1'b0;
        end else begin
            fontReady <= 1'b0;
            case (state)
                IDLE: begin
                    if (drawChar) begin
                        state <= FETCH;
                        busy  <= 1'b1;
                    end
                end
                FETCH: begin
                    state     <= START; // Shape is valid from the next cycle.
                    fontReady <= 1'b1;
                end
                START: begin
                    if (!done) state <= WAIT_DONE; // Renderer has left its done state.
                end
                WAIT_DONE: begin
                    if (done) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Colours and base are frozen for the whole cell.
    always_ff @(posedge clk) begin
        if (accept) begin
            command     <= drawCommand;
            fgLatched   <= foreground;
            bgLatched   <= background;
            baseLatched <= frameBase;
        end
    end

    assign readCode = command.code;
    assign grid = {shape, fgLatched, bgLatched};
    assign baseAddress = baseLatched
        + consoleTypes_pkg::SramAddress_t'(command.row)
            * consoleTypes_pkg::SramAddress_t'(RowStride)
        + consoleTypes_pkg::SramAddress_t'(command.column)
            * consoleTypes_pkg::SramAddress_t'(`WIDTH_PER_CHARACTER);

endmodule

//--- hdl/consoleRegs.sv
`timescale 1ns/10ps

module consoleRegs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          regWrite,
    input  consoleTypes_pkg::RegSelect_t  regSelect,
    input  consoleTypes_pkg::SramAddress_t regData,
    output consoleTypes_pkg::Color_t      foreground,
    output consoleTypes_pkg::Color_t      background,
    output consoleTypes_pkg::SramAddress_t frameBase
);

    // White text on black, frame at address zero.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            foreground <= 16'hFFFF;
            background <= 16'h0000;
            frameBase  <= 20'h00000;
        end else if (regWrite) begin
            case (regSelect)
                consoleTypes_pkg::REG_FOREGROUND: begin
                    foreground <= regData[15:0]; // Colours use the low half word.
                end
                consoleTypes_pkg::REG_BACKGROUND: begin
                    background <= regData[15:0];
                end
                consoleTypes_pkg::REG_FRAME_BASE: begin
                    frameBase <= regData;
                end
                default: begin
                    frameBase <= frameBase; // Unused select code, write dropped.
                end
            endcase
        end
    end

endmodule

//--- hdl/consoleTop.sv
`timescale 1ns/10ps

module consoleTop (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           regWrite,
    input  consoleTypes_pkg::RegSelect_t   regSelect,
    input  consoleTypes_pkg::SramAddress_t regData,
    input  logic                           glyphWrite,
    input  consoleTypes_pkg::GlyphCode_t   glyphCode,
    input  logic [3:0]                     glyphRow,
    input  consoleTypes_pkg::GlyphRow_t    glyphBits,
    input  logic                           drawChar,
    input  consoleTypes_pkg::DrawCommand_t drawCommand,
    output logic                           busy,
    output consoleTypes_pkg::SramBus_t     sramBus
);

    consoleTypes_pkg::Color_t       foreground, background;
    consoleTypes_pkg::SramAddress_t frameBase, baseAddress;
    consoleTypes_pkg::GlyphCode_t   readCode;
    consoleTypes_pkg::GlyphShape_t  shape;
    consoleTypes_pkg::CharGrid_t    grid;
    consoleTypes_pkg::SramRequest_t ramRequest;
    consoleTypes_pkg::SramResult_t  ramResult;
    logic fontReady, done;

    consoleRegs regs_i (
        .clk, .rst, .regWrite, .regSelect, .regData,
        .foreground, .background, .frameBase
    );

    fontStore fontStore_i (
        .clk, .rst, .glyphWrite, .glyphCode, .glyphRow, .glyphBits,
        .readCode, .shape
    );

    charDispatcher dispatcher_i (
        .clk, .rst, .drawChar, .drawCommand, .foreground, .background, .frameBase,
        .shape, .done, .readCode, .grid, .baseAddress, .fontReady, .busy
    );

    fontShapeRenderer renderer_i (
        .clk, .rst, .fontReady, .grid, .baseAddress, .ramResult, .ramRequest, .done
    );

    sramWritePort writePort_i (
        .clk, .rst, .ramRequest, .ramResult, .sramBus
    );

endmodule

//--- hdl/fontStore.sv
`timescale 1ns/10ps
`include "console_defines.svh"

module fontStore (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          glyphWrite,
    input  consoleTypes_pkg::GlyphCode_t  glyphCode,
    input  logic [3:0]                    glyphRow,
    input  consoleTypes_pkg::GlyphRow_t   glyphBits,
    input  consoleTypes_pkg::GlyphCode_t  readCode,
    output consoleTypes_pkg::GlyphShape_t shape
);

    consoleTypes_pkg::GlyphRow_t glyphs [`GLYPH_COUNT][`HEIGHT_PER_CHARACTER];

    // Rows are written one at a time by the host.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int g = 0; g < `GLYPH_COUNT; g++) begin
                for (int r = 0; r < `HEIGHT_PER_CHARACTER; r++) begin
                    glyphs[g][r] <= '0;
                end
            end
        end else if (glyphWrite) begin
            glyphs[glyphCode][glyphRow] <= glyphBits;
        end
    end

    // Row 0 lands in the top byte, so bit 127 is the top-left pixel.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shape <= '0;
        end else begin
            for (int r = 0; r < `HEIGHT_PER_CHARACTER; r++) begin
                shape[`PIXEL_PER_CHARACTER - 1 - r * `WIDTH_PER_CHARACTER -: `WIDTH_PER_CHARACTER]
                    <= glyphs[readCode][r];
            end
        end
    end

endmodule

//--- render/fontShapeRenderer.sv
`timescale 1ns/10ps
`include "console_defines.svh"

module fontShapeRenderer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fontReady,
    input  consoleTypes_pkg::CharGrid_t    grid,
    input  consoleTypes_pkg::SramAddress_t baseAddress,
    input  consoleTypes_pkg::SramResult_t  ramResult,
    output consoleTypes_pkg::SramRequest_t ramRequest,
    output logic                           done
);

    localparam int LinePixels = `CONSOLE_COLUMNS * `WIDTH_PER_CHARACTER;
    localparam int IndexWidth = $clog2(`PIXEL_PER_CHARACTER);

    typedef enum logic [1:0] {
        STATE_INIT,
        STATE_WAIT_WRITE,
        STATE_DONE
    } RendererState_t;

    RendererState_t currentState, nextState;
    logic [$clog2(`WIDTH_PER_CHARACTER)-1:0] x, nextX;
    logic [$clog2(`HEIGHT_PER_CHARACTER)-1:0] y, nextY;
    consoleTypes_pkg::CharGrid_t gridData, nowGrid;
    consoleTypes_pkg::SramAddress_t baseAddressData, nowBase;
    logic [IndexWidth-1:0] pixelIndex;

    assign done = currentState == STATE_DONE;

    // During INIT the inputs are used directly, afterwards the latched copy.
    assign nowGrid = (currentState == STATE_INIT) ? grid : gridData;
    assign nowBase = (currentState == STATE_INIT) ? baseAddress : baseAddressData;

    // Shape bits run from the MSB, so pixel (0,0) is the top bit.
    assign pixelIndex = IndexWidth'(`PIXEL_PER_CHARACTER - 1 - (y * `WIDTH_PER_CHARACTER + x));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x <= '0;
            y <= '0;
            currentState <= STATE_DONE; // Idle at power-up, no cell is painted.
        end else begin
            x <= nextX;
            y <= nextY;
            currentState <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (currentState == STATE_INIT) begin
            gridData        <= grid;
            baseAddressData <= baseAddress;
        end
    end

    always_comb begin
        nextX = '0;
        nextY = '0;
        nextState = STATE_INIT;
        ramRequest.address = nowBase
            + consoleTypes_pkg::SramAddress_t'(y) * consoleTypes_pkg::SramAddress_t'(LinePixels)
            + consoleTypes_pkg::SramAddress_t'(x);
        ramRequest.dout = nowGrid.shape[pixelIndex] ? nowGrid.foreground : nowGrid.background;
        ramRequest.den  = 1'b1;
        ramRequest.we_n = 1'b0;
        ramRequest.oe_n = 1'b1; // Write only.
        case (currentState)
            STATE_INIT: begin
                nextState = STATE_WAIT_WRITE;
            end
            STATE_WAIT_WRITE: begin
                nextState = STATE_WAIT_WRITE;
                nextX = x;
                nextY = y;
                if (ramResult.done) begin
                    if (x == `WIDTH_PER_CHARACTER - 1) begin
                        nextX = '0;
                        if (y == `HEIGHT_PER_CHARACTER - 1) begin
                            nextY = '0;
                            nextState = STATE_DONE;
                        end else begin
                            nextY = y + 1'b1;
                        end
                    end else begin
                        nextX = x + 1'b1;
                    end
                end
            end
            default: begin
                ramRequest.den  = 1'b0;
                ramRequest.we_n = 1'b1;
                nextState = fontReady ? STATE_INIT : STATE_DONE;
            end
        endcase
    end

endmodule

//--- render/sramWritePort.sv
`timescale 1ns/10ps
`include "console_defines.svh"

module sramWritePort (
    input  logic                           clk,
    input  logic                           rst,
    input  consoleTypes_pkg::SramRequest_t ramRequest,
    output consoleTypes_pkg::SramResult_t  ramResult,
    output consoleTypes_pkg::SramBus_t     sramBus
);

    localparam int CountWidth = ($clog2(`SRAM_WRITE_CYCLES) > 0) ? $clog2(`SRAM_WRITE_CYCLES) : 1;

    logic [CountWidth-1:0] cycleCount;
    logic writeActive;
    logic lastCycle;
    logic doneReg;
    logic ceReg, weReg, oeReg;
    consoleTypes_pkg::SramAddress_t addressReg;
    consoleTypes_pkg::Color_t dataReg;

    assign writeActive = ramRequest.den && !ramRequest.we_n;
    assign lastCycle = cycleCount == CountWidth'(`SRAM_WRITE_CYCLES - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycleCount <= '0;
            doneReg <= 1'b0;
            ceReg <= 1'b1;
            weReg <= 1'b1;
            oeReg <= 1'b1;
        end else begin
            doneReg <= writeActive && lastCycle; // One pulse per completed pixel.
            if (!writeActive || lastCycle) cycleCount <= '0;
            else cycleCount <= cycleCount + 1'b1;
            ceReg <= !writeActive;
            weReg <= !writeActive;
            oeReg <= writeActive ? ramRequest.oe_n : 1'b1;
        end
    end

    // Address and data follow the request while a write is in progress.
    always_ff @(posedge clk) begin
        if (writeActive) begin
            addressReg <= ramRequest.address;
            dataReg    <= ramRequest.dout;
        end
    end

    assign ramResult.done = doneReg;
    assign sramBus = {addressReg, dataReg, ceReg, weReg, oeReg};

endmodule
